// ==== scene_defs.svh ====
`ifndef SCENE_DEFS_SVH
`define SCENE_DEFS_SVH

`define SCENE_NUM_PLAYERS 2
`define SCENE_COORD_W 10

// terrain rows, inclusive
`define SCENE_SKY_LAST 400
`define SCENE_GRASS_LAST 420

// character block
`define SCENE_CHAR_W 16
`define SCENE_CHAR_H 24

// turn marker, one column per player
`define SCENE_MARKER_Y 80
`define SCENE_MARKER_W 8
`define SCENE_MARKER_H 16
`define SCENE_MARKER_X0 20
`define SCENE_MARKER_X1 612

`define SCENE_BALL_SIZE_MAX 15

`define SCENE_RGB_SKY 24'h00bfff
`define SCENE_RGB_GRASS 24'h00cc00
`define SCENE_RGB_MUD 24'h993300
`define SCENE_RGB_BALL 24'h0000ff
`define SCENE_RGB_CHAR0 24'hff2020
`define SCENE_RGB_CHAR1 24'hffffff
`define SCENE_RGB_MARKER 24'hffff00

`endif

// ==== scene_pkg.sv ====
`include "scene_defs.svh"

package scene_pkg;

	typedef logic [`SCENE_COORD_W-1:0] coord_t; // screen x or y

	typedef struct packed
	{
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// row band of the background
	typedef enum logic [1:0]
	{
		TERRAIN_SKY,
		TERRAIN_GRASS,
		TERRAIN_MUD
	} terrain_e;

	// which layer owns a pixel
	typedef enum logic [1:0]
	{
		LAYER_TERRAIN,
		LAYER_BALL,
		LAYER_CHAR,
		LAYER_MARKER
	} layer_e;

endpackage

// ==== pixel_stage.sv ====
`timescale 1ns/1ps
`include "scene_defs.svh"

module pixel_stage
	import scene_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     pix_valid,
	input  coord_t   draw_x,
	input  coord_t   draw_y,
	output logic     s1_valid,
	output coord_t   s1_x,
	output coord_t   s1_y,
	output logic     s2_valid,
	output terrain_e s2_terrain
);

	terrain_e band;
	terrain_e s1_terrain;

	always_comb
	begin
		if (draw_y <= coord_t'(`SCENE_SKY_LAST))
			band = TERRAIN_SKY;
		else if (draw_y <= coord_t'(`SCENE_GRASS_LAST))
			band = TERRAIN_GRASS;
		else
			band = TERRAIN_MUD;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= pix_valid;
			s2_valid <= s1_valid;
		end
	end

	// pixel payload, band rides one stage behind
	always_ff @(posedge clk)
	begin
		s1_x       <= draw_x;
		s1_y       <= draw_y;
		s1_terrain <= band;
		s2_terrain <= s1_terrain; // lines up with layer hits
	end

	a_coord_known: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid |-> !$isunknown({draw_x, draw_y}));

endmodule

// ==== player_layer.sv ====
`timescale 1ns/1ps
`include "scene_defs.svh"

module player_layer
	import scene_pkg::*;
#(
	parameter int PLAYER_IDX = 0
)
(
	input  logic   clk,
	input  logic   rst_n,
	input  coord_t s1_x,
	input  coord_t s1_y,
	input  coord_t char_x,
	input  coord_t char_y,
	input  coord_t ball_x,
	input  coord_t ball_y,
	input  coord_t ball_size,
	input  logic   ball_show,
	input  logic   turn_p1,
	output logic   char_hit,
	output logic   ball_hit,
	output logic   marker_hit
);

	localparam int MARKER_X = (PLAYER_IDX == 0) ? `SCENE_MARKER_X0 : `SCENE_MARKER_X1;

	logic [`SCENE_COORD_W:0] char_x_end; // one past the block, no wrap
	logic [`SCENE_COORD_W:0] char_y_end;
	logic signed [`SCENE_COORD_W:0] dx;
	logic signed [`SCENE_COORD_W:0] dy;
	logic [2*`SCENE_COORD_W+1:0] dist_sq;
	logic [2*`SCENE_COORD_W-1:0] rad_sq;
	logic my_turn;
	logic char_on;
	logic ball_on;
	logic marker_on;

	assign char_x_end = {1'b0, char_x} + (`SCENE_COORD_W+1)'(`SCENE_CHAR_W);
	assign char_y_end = {1'b0, char_y} + (`SCENE_COORD_W+1)'(`SCENE_CHAR_H);

	assign char_on = (s1_x >= char_x) && ({1'b0, s1_x} < char_x_end)
		&& (s1_y >= char_y) && ({1'b0, s1_y} < char_y_end);

	// signed offsets from the ball centre
	assign dx = $signed({1'b0, s1_x}) - $signed({1'b0, ball_x});
	assign dy = $signed({1'b0, s1_y}) - $signed({1'b0, ball_y});
	assign dist_sq = dx * dx + dy * dy;
	assign rad_sq = ball_size * ball_size;

	assign ball_on = ball_show && (dist_sq <= {2'b00, rad_sq});

	// player 0 plays while turn_p1 is set
	assign my_turn = (PLAYER_IDX == 0) ? turn_p1 : !turn_p1;

	assign marker_on = my_turn
		&& (s1_x >= coord_t'(MARKER_X))
		&& (s1_x < coord_t'(MARKER_X + `SCENE_MARKER_W))
		&& (s1_y >= coord_t'(`SCENE_MARKER_Y))
		&& (s1_y < coord_t'(`SCENE_MARKER_Y + `SCENE_MARKER_H));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			char_hit   <= 1'b0;
			ball_hit   <= 1'b0;
			marker_hit <= 1'b0;
		end
		else
		begin
			char_hit   <= char_on;
			ball_hit   <= ball_on;
			marker_hit <= marker_on;
		end
	end

	a_ball_size: assert property (@(posedge clk) disable iff (!rst_n)
		ball_size <= coord_t'(`SCENE_BALL_SIZE_MAX));

endmodule

// ==== layer_compositor.sv ====
`timescale 1ns/1ps
`include "scene_defs.svh"

module layer_compositor
	import scene_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          s2_valid,
	input  terrain_e                      s2_terrain,
	input  logic [`SCENE_NUM_PLAYERS-1:0] char_hit,
	input  logic [`SCENE_NUM_PLAYERS-1:0] ball_hit,
	input  logic [`SCENE_NUM_PLAYERS-1:0] marker_hit,
	output logic                          rgb_valid,
	output rgb_t                          rgb
);

	layer_e win_layer;
	rgb_t   rgb_next;

	// marker over characters over balls over ground
	always_comb
	begin
		if (|marker_hit)
			win_layer = LAYER_MARKER;
		else if (|char_hit)
			win_layer = LAYER_CHAR;
		else if (|ball_hit)
			win_layer = LAYER_BALL;
		else
			win_layer = LAYER_TERRAIN;
	end

	always_comb
	begin
		case (win_layer)
			LAYER_MARKER: rgb_next = rgb_t'(`SCENE_RGB_MARKER);
			LAYER_CHAR: rgb_next = char_hit[0] ? rgb_t'(`SCENE_RGB_CHAR0)
				: rgb_t'(`SCENE_RGB_CHAR1); // player 0 on top
			LAYER_BALL: rgb_next = rgb_t'(`SCENE_RGB_BALL);
			default:
			begin
				case (s2_terrain)
					TERRAIN_SKY: rgb_next = rgb_t'(`SCENE_RGB_SKY);
					TERRAIN_GRASS: rgb_next = rgb_t'(`SCENE_RGB_GRASS);
					default: rgb_next = rgb_t'(`SCENE_RGB_MUD);
				endcase
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rgb_valid <= 1'b0;
			rgb       <= '0;
		end
		else
		begin
			rgb_valid <= s2_valid;
			if (s2_valid)
				rgb <= rgb_next; // hold last colour in bubbles
		end
	end

	a_valid_in_reset: assert property (@(posedge clk) !rst_n |-> !rgb_valid);

	a_valid_follow: assert property (@(posedge clk) disable iff (!rst_n)
		s2_valid |=> rgb_valid);

	a_bubble_follow: assert property (@(posedge clk) disable iff (!rst_n)
		!s2_valid |=> !rgb_valid);

	// hits from both player layers must be resolved for a live pixel
	a_layer_known: assert property (@(posedge clk) disable iff (!rst_n)
		s2_valid |-> !$isunknown({char_hit, ball_hit, marker_hit}));

endmodule

// ==== scene_mapper.sv ====
`timescale 1ns/1ps
`include "scene_defs.svh"

module scene_mapper
	import scene_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          pix_valid,
	input  coord_t                        draw_x,
	input  coord_t                        draw_y,
	input  coord_t                        char_x [`SCENE_NUM_PLAYERS],
	input  coord_t                        char_y [`SCENE_NUM_PLAYERS],
	input  coord_t                        ball_x [`SCENE_NUM_PLAYERS],
	input  coord_t                        ball_y [`SCENE_NUM_PLAYERS],
	input  coord_t                        ball_size [`SCENE_NUM_PLAYERS],
	input  logic [`SCENE_NUM_PLAYERS-1:0] ball_show,
	input  logic                          turn_p1,
	output logic                          rgb_valid,
	output logic [7:0]                    red,
	output logic [7:0]                    green,
	output logic [7:0]                    blue
);

	coord_t   s1_x;
	coord_t   s1_y;
	logic     s2_valid;
	terrain_e s2_terrain;
	logic [`SCENE_NUM_PLAYERS-1:0] char_hit;
	logic [`SCENE_NUM_PLAYERS-1:0] ball_hit;
	logic [`SCENE_NUM_PLAYERS-1:0] marker_hit;
	rgb_t     rgb;

	pixel_stage i_pixel_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.pix_valid  (pix_valid),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.s1_valid   (),
		.s1_x       (s1_x),
		.s1_y       (s1_y),
		.s2_valid   (s2_valid),
		.s2_terrain (s2_terrain)
	);

	layer_compositor i_layer_compositor (
		.clk        (clk),
		.rst_n      (rst_n),
		.s2_valid   (s2_valid),
		.s2_terrain (s2_terrain),
		.char_hit   (char_hit),
		.ball_hit   (ball_hit),
		.marker_hit (marker_hit),
		.rgb_valid  (rgb_valid),
		.rgb        (rgb)
	);

	// one hit tester per player
	for (genvar p = 0; p < `SCENE_NUM_PLAYERS; p++)
	begin : g_player
		player_layer #(
			.PLAYER_IDX (p)
		) i_player_layer (
			.clk        (clk),
			.rst_n      (rst_n),
			.s1_x       (s1_x),
			.s1_y       (s1_y),
			.char_x     (char_x[p]),
			.char_y     (char_y[p]),
			.ball_x     (ball_x[p]),
			.ball_y     (ball_y[p]),
			.ball_size  (ball_size[p]),
			.ball_show  (ball_show[p]),
			.turn_p1    (turn_p1),
			.char_hit   (char_hit[p]),
			.ball_hit   (ball_hit[p]),
			.marker_hit (marker_hit[p])
		);
	end

	assign red   = rgb.r;
	assign green = rgb.g;
	assign blue  = rgb.b;

endmodule

// ==== tb_scene_mapper.sv ====
`timescale 1ns/1ps
`include "scene_defs.svh"

module tb_scene_mapper
	import scene_pkg::*;
();

	localparam int TERRAIN_ROWS [6] = '{0, 400, 401, 420, 421, 479};

	logic   clk;
	logic   rst_n;
	logic   pix_valid;
	coord_t draw_x;
	coord_t draw_y;
	coord_t char_x [`SCENE_NUM_PLAYERS];
	coord_t char_y [`SCENE_NUM_PLAYERS];
	coord_t ball_x [`SCENE_NUM_PLAYERS];
	coord_t ball_y [`SCENE_NUM_PLAYERS];
	coord_t ball_size [`SCENE_NUM_PLAYERS];
	logic [`SCENE_NUM_PLAYERS-1:0] ball_show;
	logic   turn_p1;
	logic   rgb_valid;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;

	logic [23:0] exp_q [$]; // expected colours in flight
	int          due_q [$]; // cycle each colour must appear in
	string       name_q [$];
	string       test_name;
	int          cyc = 0;
	logic [31:0] rng_state = 32'h7859;

	scene_mapper i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			fail_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic int rand_below(input int n);
		rng_state = xorshift(rng_state);
		return int'(rng_state % n);
	endfunction

	// colour of one pixel for the current object settings
	function automatic logic [23:0] expected_rgb(input int x, input int y);
		logic [1:0] ch;
		logic [1:0] bh;
		logic [1:0] mh;
		int mx;
		int dx;
		int dy;
		for (int p = 0; p < 2; p++)
		begin
			mx = (p == 0) ? `SCENE_MARKER_X0 : `SCENE_MARKER_X1;
			dx = x - int'(ball_x[p]);
			dy = y - int'(ball_y[p]);
			ch[p] = x >= int'(char_x[p]) && x < int'(char_x[p]) + `SCENE_CHAR_W
				&& y >= int'(char_y[p]) && y < int'(char_y[p]) + `SCENE_CHAR_H;
			bh[p] = ball_show[p] && (dx * dx + dy * dy <= int'(ball_size[p]) * int'(ball_size[p]));
			mh[p] = ((p == 0) == turn_p1) && x >= mx && x < mx + `SCENE_MARKER_W
				&& y >= `SCENE_MARKER_Y && y < `SCENE_MARKER_Y + `SCENE_MARKER_H;
		end
		if (|mh)
			return `SCENE_RGB_MARKER;
		if (ch[0])
			return `SCENE_RGB_CHAR0;
		if (ch[1])
			return `SCENE_RGB_CHAR1;
		if (|bh)
			return `SCENE_RGB_BALL;
		if (y <= `SCENE_SKY_LAST)
			return `SCENE_RGB_SKY;
		if (y <= `SCENE_GRASS_LAST)
			return `SCENE_RGB_GRASS;
		return `SCENE_RGB_MUD;
	endfunction

	task automatic send_pixel(input int x, input int y);
		@(negedge clk);
		pix_valid = 1'b1;
		draw_x = coord_t'(x);
		draw_y = coord_t'(y);
		exp_q.push_back(expected_rgb(x, y));
		due_q.push_back(cyc + 3);
		name_q.push_back(test_name);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge clk);
			pix_valid = 1'b0;
		end
	endtask

	// wait until every pixel in flight has been checked
	task automatic drain_pipe();
		int waited;
		idle_cycles(1);
		waited = 0;
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
			waited++;
			if (waited > 20)
				fail_run($sformatf("rgb_valid never came for %0d pixels of test %s",
					exp_q.size(), test_name));
		end
		@(negedge clk);
	endtask

	task automatic park_objects();
		for (int p = 0; p < 2; p++)
		begin
			char_x[p] = 10'd1000; // off screen
			char_y[p] = 10'd1000;
			ball_x[p] = 10'd1000;
			ball_y[p] = 10'd1000;
			ball_size[p] = '0;
		end
		ball_show = '0;
	endtask

	task automatic char_edges(input int p);
		int cx;
		int cy;
		cx = char_x[p];
		cy = char_y[p];
		send_pixel(cx - 1, cy);
		send_pixel(cx, cy);
		send_pixel(cx + `SCENE_CHAR_W - 1, cy + `SCENE_CHAR_H - 1);
		send_pixel(cx + `SCENE_CHAR_W, cy + `SCENE_CHAR_H - 1);
		send_pixel(cx, cy - 1);
		send_pixel(cx + `SCENE_CHAR_W - 1, cy + `SCENE_CHAR_H);
	endtask

	// on the rim, then one step outside
	task automatic ball_axis(input int p);
		int bx;
		int by;
		int r;
		bx = ball_x[p];
		by = ball_y[p];
		for (r = ball_size[p]; r <= ball_size[p] + 1; r++)
		begin
			send_pixel(bx - r, by);
			send_pixel(bx + r, by);
			send_pixel(bx, by - r);
			send_pixel(bx, by + r);
		end
	endtask

	task automatic marker_corners(input int mx);
		send_pixel(mx, `SCENE_MARKER_Y);
		send_pixel(mx + `SCENE_MARKER_W - 1, `SCENE_MARKER_Y + `SCENE_MARKER_H - 1);
		send_pixel(mx + `SCENE_MARKER_W, `SCENE_MARKER_Y);
		send_pixel(mx - 1, `SCENE_MARKER_Y + `SCENE_MARKER_H - 1);
	endtask

	initial
	begin
		logic [23:0] exp_rgb;
		string name;
		int due;
		forever
		begin
			@(negedge clk);
			if (!rst_n)
				check_value("reset", 32'd0, {31'd0, rgb_valid});
			else if (rgb_valid)
			begin
				if (exp_q.size() == 0)
					fail_run("rgb_valid was high with no pixel in flight");
				else
				begin
					exp_rgb = exp_q.pop_front();
					due = due_q.pop_front();
					name = name_q.pop_front();
					check_value({name, " latency"}, due, cyc);
					check_value(name, {8'd0, exp_rgb}, {8'd0, red, green, blue});
				end
			end
		end
	end

	initial
	begin
		int bx;
		int by;
		int x;
		int y;
		int p;
		int sel;
		rst_n = 1'b0;
		pix_valid = 1'b0;
		draw_x = '0;
		draw_y = '0;
		turn_p1 = 1'b1;
		park_objects();
		test_name = "reset";
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		idle_cycles(4);

		test_name = "latency";
		send_pixel(300, 100);
		idle_cycles(6);
		send_pixel(301, 100);
		idle_cycles(1);
		send_pixel(302, 100);
		send_pixel(303, 100);
		idle_cycles(2);
		send_pixel(304, 100);
		drain_pipe();

		test_name = "terrain";
		foreach (TERRAIN_ROWS[i])
			send_pixel(300, TERRAIN_ROWS[i]);
		drain_pipe();

		test_name = "characters";
		char_x[0] = 10'd100;
		char_y[0] = 10'd200;
		char_x[1] = 10'd108;
		char_y[1] = 10'd210;
		char_edges(0);
		char_edges(1);
		send_pixel(110, 212); // both blocks overlap here
		drain_pipe();

		park_objects();
		test_name = "ball";
		ball_x[0] = 10'd300;
		ball_y[0] = 10'd300;
		ball_size[0] = 10'd10;
		ball_x[1] = 10'd400;
		ball_y[1] = 10'd250;
		ball_size[1] = 10'd15;
		ball_show = 2'b11;
		ball_axis(0);
		ball_axis(1);
		drain_pipe();
		test_name = "ball hidden";
		ball_show = 2'b00;
		ball_axis(0);
		ball_axis(1);
		drain_pipe();
		test_name = "char over ball";
		ball_show = 2'b11;
		char_x[1] = 10'd295;
		char_y[1] = 10'd295;
		send_pixel(300, 300);
		send_pixel(400, 250);
		drain_pipe();

		park_objects();
		for (int t = 1; t >= 0; t--)
		begin
			turn_p1 = t[0];
			test_name = $sformatf("marker turn_p1=%0d", t);
			marker_corners(`SCENE_MARKER_X0);
			marker_corners(`SCENE_MARKER_X1);
			drain_pipe();
		end
		test_name = "marker over char";
		turn_p1 = 1'b1;
		char_x[0] = coord_t'(`SCENE_MARKER_X0);
		char_y[0] = coord_t'(`SCENE_MARKER_Y);
		marker_corners(`SCENE_MARKER_X0);
		drain_pipe();

		test_name = "random";
		for (p = 0; p < 2; p++)
		begin
			char_x[p] = coord_t'(rand_below(640 - `SCENE_CHAR_W));
			char_y[p] = coord_t'(rand_below(480 - `SCENE_CHAR_H));
			ball_x[p] = coord_t'(rand_below(640));
			ball_y[p] = coord_t'(rand_below(480));
			ball_size[p] = coord_t'(rand_below(`SCENE_BALL_SIZE_MAX + 1));
			ball_show[p] = 1'(rand_below(2));
		end
		turn_p1 = 1'(rand_below(2));
		for (int i = 0; i < 400; i++)
		begin
			p = rand_below(2);
			sel = rand_below(4);
			bx = rand_below(640);
			by = rand_below(480);
			if (sel == 1)
			begin
				bx = char_x[p];
				by = char_y[p];
			end
			else if (sel == 2)
			begin
				bx = ball_x[p];
				by = ball_y[p];
			end
			else if (sel == 3)
			begin
				bx = (p == 0) ? `SCENE_MARKER_X0 : `SCENE_MARKER_X1;
				by = `SCENE_MARKER_Y;
			end
			x = (bx + rand_below(41) + 620) % 640; // within 20 of the object
			y = (by + rand_below(41) + 460) % 480;
			send_pixel(x, y);
		end
		drain_pipe();

		if (exp_q.size() == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
			fail_run("pixels were still pending at the end of the run");
	end

endmodule

// ==== scene_mapper.f ====
+incdir+.
scene_pkg.sv
pixel_stage.sv
player_layer.sv
layer_compositor.sv
scene_mapper.sv
tb_scene_mapper.sv

// ==== Bender.yml ====
package:
  name: scene_mapper

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - scene_pkg.sv
      - pixel_stage.sv
      - player_layer.sv
      - layer_compositor.sv
      - scene_mapper.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_scene_mapper.sv
